/* rtl/dadda_multiplier_8.sv */
`timescale 1ns/1ps

module dadda_multiplier_8 (
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic [15:0] product
);

    logic [7:0] pp [8]; // pp[i][j] has weight i+j

    logic [3:0] s1, s2, s3, s4, s5, s7, s8, s9;
    logic [1:0] s6;
    logic       c1, c2, c3, c4, c5, c6, c7, c8, c9;

    logic       ha_s, ha_c;   // column 1
    logic [8:1] fa_s, fa_c;   // columns 2 to 9

    logic [12:0] fin_sum;
    logic        fin_cout;

    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign pp[i] = b & {8{a[i]}};
    end

    // first row of prefix adders, inputs low weight first
    kogge_stone_adder #(.WIDTH(4)) ks1_i ( // weights 6..9
        .in1(pp[2][7:4]), .in2(pp[3][6:3]), .cin(1'b0), .sum(s1), .cout(c1)
    );

    kogge_stone_adder #(.WIDTH(4)) ks2_i ( // weights 5..8
        .in1(pp[4][4:1]), .in2(pp[5][3:0]), .cin(1'b0), .sum(s2), .cout(c2)
    );

    kogge_stone_adder #(.WIDTH(4)) ks3_i ( // weights 7..10
        .in1(pp[6][4:1]), .in2(pp[7][3:0]), .cin(1'b0), .sum(s3), .cout(c3)
    );

    kogge_stone_adder #(.WIDTH(4)) ks4_i ( // weights 3..6
        .in1(pp[0][6:3]), .in2(pp[1][5:2]), .cin(1'b0), .sum(s4), .cout(c4)
    );

    // second row folds in sums from the first
    kogge_stone_adder #(.WIDTH(4)) ks5_i ( // weights 7..10
        .in1 ({pp[3][7], pp[4][5], pp[1][7], pp[0][7]}),
        .in2 ({pp[4][6], pp[5][4], s1[2], pp[1][6]}),
        .cin (s3[0]),
        .sum (s5),
        .cout(c5)
    );

    kogge_stone_adder #(.WIDTH(2)) ks6_i ( // weights 11..12
        .in1 ({pp[5][7], pp[4][7]}),
        .in2 ({pp[6][6], pp[5][6]}),
        .cin (pp[6][5]),
        .sum (s6),
        .cout(c6)
    );

    kogge_stone_adder #(.WIDTH(4)) ks7_i ( // weights 4..7
        .in1 ({s1[1], pp[6][0], pp[2][3:2]}),
        .in2 ({s2[2], s1[0], pp[3][2:1]}),
        .cin (1'b0),
        .sum (s7),
        .cout(c7)
    );

    kogge_stone_adder #(.WIDTH(4)) ks8_i ( // weights 8..11
        .in1 ({c3, pp[5][5], s1[3], s2[3]}),
        .in2 ({pp[7][4], c1, c2, s3[1]}),
        .cin (1'b0),
        .sum (s8),
        .cout(c8)
    );

    // low columns, half and full adders
    assign ha_s = pp[0][1] ^ pp[1][0];
    assign ha_c = pp[0][1] & pp[1][0];

    assign fa_s[1] = pp[0][2] ^ pp[1][1] ^ pp[2][0];
    assign fa_c[1] = (pp[0][2] & pp[1][1]) | (pp[0][2] & pp[2][0]) | (pp[1][1] & pp[2][0]);
    assign fa_s[2] = pp[2][1] ^ pp[3][0] ^ s4[0];
    assign fa_c[2] = (pp[2][1] & pp[3][0]) | (pp[2][1] & s4[0]) | (pp[3][0] & s4[0]);
    assign fa_s[3] = pp[4][0] ^ s4[1] ^ s7[0];
    assign fa_c[3] = (pp[4][0] & s4[1]) | (pp[4][0] & s7[0]) | (s4[1] & s7[0]);
    assign fa_s[4] = s2[0] ^ s4[2] ^ s7[1];
    assign fa_c[4] = (s2[0] & s4[2]) | (s2[0] & s7[1]) | (s4[2] & s7[1]);
    assign fa_s[5] = s2[1] ^ s4[3] ^ s7[2];
    assign fa_c[5] = (s2[1] & s4[3]) | (s2[1] & s7[2]) | (s4[3] & s7[2]);
    assign fa_s[6] = c4 ^ s5[0] ^ s7[3];
    assign fa_c[6] = (c4 & s5[0]) | (c4 & s7[3]) | (s5[0] & s7[3]);
    assign fa_s[7] = s5[1] ^ c7 ^ s8[0];
    assign fa_c[7] = (s5[1] & c7) | (s5[1] & s8[0]) | (c7 & s8[0]);
    assign fa_s[8] = s3[2] ^ s5[2] ^ s8[1];
    assign fa_c[8] = (s3[2] & s5[2]) | (s3[2] & s8[1]) | (s5[2] & s8[1]);

    kogge_stone_adder #(.WIDTH(4)) ks9_i ( // weights 10..13
        .in1 ({pp[6][7], pp[7][5], c5, s3[3]}),
        .in2 ({pp[7][6], s6[1], s6[0], s5[3]}),
        .cin (s8[2]),
        .sum (s9),
        .cout(c9)
    );

    // carry-save pair for weights 2..14
    kogge_stone_adder #(.WIDTH(13)) ks_final_i (
        .in1 ({pp[7][7], s9, fa_s[8:1]}),
        .in2 ({c9, c6, c8, s8[3], fa_c[8:1], ha_c}),
        .cin (1'b0),
        .sum (fin_sum),
        .cout(fin_cout)
    );

    assign product = {fin_cout, fin_sum, ha_s, pp[0][0]};

endmodule

/* rtl/dot_accumulator.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module dot_accumulator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mult_pkg::lane_result_t lane0,
    input  mult_pkg::lane_result_t lane1,
    output mult_pkg::dot_result_t  res,
    output logic                   out_valid
);

    localparam int PAD_W = `ACC_W - `PRODUCT_W;

    logic [`ACC_W-1:0] pair_sum;  // product0 + product1
    logic [`ACC_W-1:0] base_sum;  // held sum or zero on clear
    logic [`ACC_W-1:0] next_sum;
    logic [`ACC_W-1:0] sum_q;
    logic              out_valid_q;

    kogge_stone_adder #(.WIDTH(`ACC_W)) pair_add_i (
        .in1 ({{PAD_W{1'b0}}, lane0.product}),
        .in2 ({{PAD_W{1'b0}}, lane1.product}),
        .cin (1'b0),
        .sum (pair_sum),
        .cout()                   // two 16-bit products never reach bit 24
    );

    assign base_sum = lane0.clear ? '0 : sum_q;

    kogge_stone_adder #(.WIDTH(`ACC_W)) acc_add_i (
        .in1 (base_sum),
        .in2 (pair_sum),
        .cin (1'b0),
        .sum (next_sum),
        .cout()                   // wraps modulo 2^24
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= lane0.valid;
            if (lane0.valid) begin
                sum_q <= next_sum;
            end
        end
    end

    assign res       = '{sum: sum_q};
    assign out_valid = out_valid_q;

    // both lanes see the same strobe
    a_lanes_in_step: assert property (
        @(posedge clk) disable iff (!rst_n) lane0.valid == lane1.valid
    ) else $error("lane valids disagree");

    // a lone request gives a single-cycle pulse
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
            $rose(out_valid_q) && !lane1.valid |=> !out_valid_q
    ) else $error("out_valid held without a following request");

endmodule

/* rtl/dot_product_top.sv */
`timescale 1ns/1ps

module dot_product_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  mult_pkg::dot_request_t req,
    output mult_pkg::dot_result_t  res,
    output logic                   out_valid
);

    mult_pkg::lane_result_t lane0_res;
    mult_pkg::lane_result_t lane1_res;

    mult_lane lane0_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .pair    (req.pair0),
        .clear   (req.clear),  // clear rides with lane 0
        .result  (lane0_res)
    );

    mult_lane lane1_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .pair    (req.pair1),
        .clear   (1'b0),
        .result  (lane1_res)
    );

    dot_accumulator acc_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .lane0    (lane0_res),
        .lane1    (lane1_res),
        .res      (res),
        .out_valid(out_valid)
    );

endmodule

/* rtl/kogge_stone_adder.sv */
`timescale 1ns/1ps

module kogge_stone_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // carry in sits at index 0 as an extra generate bit
    localparam int N      = WIDTH + 1;
    localparam int LEVELS = $clog2(N);

    logic [WIDTH-1:0] p_bit;             // per-bit propagate
    logic [N-1:0]     g_lvl [LEVELS+1];  // group generate per level
    logic [N-1:0]     p_lvl [LEVELS];    // group propagate, last level not needed

    assign p_bit    = in1 ^ in2;
    assign g_lvl[0] = {in1 & in2, cin};
    assign p_lvl[0] = {p_bit, 1'b0}; // nothing propagates past cin

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        for (genvar i = 0; i < N; i++) begin : g_bit
            if (i >= (1 << lvl)) begin : g_cell
                // black cell, gray where propagate is dropped
                assign g_lvl[lvl+1][i] = g_lvl[lvl][i] |
                                         (p_lvl[lvl][i] & g_lvl[lvl][i-(1<<lvl)]);
                if (lvl < LEVELS - 1) begin : g_prop
                    assign p_lvl[lvl+1][i] = p_lvl[lvl][i] & p_lvl[lvl][i-(1<<lvl)];
                end
            end else begin : g_pass
                assign g_lvl[lvl+1][i] = g_lvl[lvl][i]; // already resolved
                if (lvl < LEVELS - 1) begin : g_prop
                    assign p_lvl[lvl+1][i] = p_lvl[lvl][i];
                end
            end
        end
    end

    // g_lvl[LEVELS][k] is the carry into bit k
    assign sum  = p_bit ^ g_lvl[LEVELS][WIDTH-1:0];
    assign cout = g_lvl[LEVELS][WIDTH];

endmodule

/* rtl/mult_defs.svh */
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// width of each multiplicand
`define OPERAND_W 8

// full product of two operands
`define PRODUCT_W 16

// running sum, wraps modulo 2^24
`define ACC_W 24

`endif

/* rtl/mult_lane.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module mult_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  mult_pkg::operand_pair_t pair,
    input  logic                    clear,
    output mult_pkg::lane_result_t  result
);

    logic [`PRODUCT_W-1:0] product;   // straight from the tree
    logic [`PRODUCT_W-1:0] product_q;
    logic                  valid_q;
    logic                  clear_q;

    dadda_multiplier_8 mult_i (
        .a      (pair.a),
        .b      (pair.b),
        .product(product)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            valid_q <= in_valid; // one cycle per strobe
            if (in_valid) begin
                clear_q <= clear;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            product_q <= product;
        end
    end

    assign result = '{valid: valid_q, clear: clear_q, product: product_q};

    // an accepted request must leave a fully known product
    a_product_known: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |=> !$isunknown(product_q)
    ) else $error("lane product has X bits after a request");

endmodule

/* rtl/mult_pkg.sv */
`include "mult_defs.svh"

package mult_pkg;

    // one multiplicand pair for a lane
    typedef struct packed {
        logic [`OPERAND_W-1:0] a;
        logic [`OPERAND_W-1:0] b;
    } operand_pair_t;

    // request as presented on the input strobe
    typedef struct packed {
        operand_pair_t pair0; // to lane 0
        operand_pair_t pair1; // to lane 1
        logic          clear; // restart the running sum
    } dot_request_t;

    // registered output of one multiplier lane
    typedef struct packed {
        logic                  valid;
        logic                  clear;   // only meaningful on lane 0
        logic [`PRODUCT_W-1:0] product;
    } lane_result_t;

    // accumulator output, room left for status bits
    typedef struct packed {
        logic [`ACC_W-1:0] sum;
    } dot_result_t;

endpackage

/* tb.f */
+incdir+rtl
rtl/mult_pkg.sv
rtl/kogge_stone_adder.sv
rtl/dadda_multiplier_8.sv
rtl/mult_lane.sv
rtl/dot_accumulator.sv
rtl/dot_product_top.sv
tb/tb_clock_gen.sv
tb/dot_product_tb.sv

/* tb/dot_product_tb.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module dot_product_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 4;
    localparam int CORNER_GAP   = 2;
    localparam int N_CORNER     = 6;
    localparam int N_RUN        = 12;
    localparam int N_MID        = 10;
    localparam int N_WRAP       = 140;  // 140 * 130050 passes 2^24
    localparam int N_RANDOM     = 300;
    localparam int MAX_GAP      = 2;
    localparam int DRAIN_LIMIT  = 8;
    localparam int N_TESTS      = 5;
    localparam int N_REQ        = N_CORNER + N_RUN + N_MID + N_WRAP + N_RANDOM;
    localparam int MAX_REQ      = 512;
    // worst case, every gap and every drain at its limit
    localparam int RUN_CYCLES   = RESET_CYCLES + IDLE_CYCLES + N_REQ
                                + N_CORNER * CORNER_GAP + N_RANDOM * MAX_GAP
                                + N_TESTS * (DRAIN_LIMIT + 1) + 20;
    localparam int WATCHDOG_NS  = RUN_CYCLES * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    mult_pkg::dot_request_t req;
    mult_pkg::dot_result_t  res;
    logic                   out_valid;

    logic [`ACC_W-1:0] model_sums [MAX_REQ]; // expected sum per request
    string             model_tests [MAX_REQ];
    logic [`ACC_W-1:0] model_acc;
    logic [`ACC_W-1:0] exp_sum;
    int                sent_count;
    int                checked_count;
    logic              req_seen;
    string             test_name;
    int                seed;

    int value_errors   = 0;
    int latency_errors = 0;
    int reset_errors   = 0;
    int missing_errors = 0;

    tb_clock_gen #(
        .PERIOD_NS   (CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    dot_product_top dot_product_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .req      (req),
        .res      (res),
        .out_valid(out_valid)
    );

    assign exp_sum = model_sums[checked_count]; // head of the model queue

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            checked_count <= 0;
            req_seen      <= 1'b0;
        end else begin
            if (out_valid) begin
                checked_count <= checked_count + 1; // pop
            end
            if (in_valid) begin
                req_seen <= 1'b1;
            end
        end
    end

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2)
    ) else begin
        latency_errors++;
        $display("out_valid at %0t ns does not follow in_valid two cycles earlier", $time);
    end

    a_idle_until_request: assert property (
        @(posedge clk) disable iff (!rst_n) !req_seen |-> !out_valid && res.sum == '0
    ) else begin
        reset_errors++;
        $display("output not idle and zero before the first request at %0t ns", $time);
    end

    a_sum_matches: assert property (
        @(posedge clk) disable iff (!rst_n)
            out_valid |-> !$isunknown(res.sum) && res.sum == exp_sum
    ) else begin
        value_errors++;
        $display("Mismatch in %s: expected %h, actual %h",
                 model_tests[$sampled(checked_count)], $sampled(exp_sum), $sampled(res.sum));
    end

    task automatic send_request(input logic [7:0] a0, input logic [7:0] b0,
                                input logic [7:0] a1, input logic [7:0] b1,
                                input logic clear);
        logic [`ACC_W-1:0] products;
        @(posedge clk);
        in_valid      <= 1'b1;
        req.pair0.a   <= a0;
        req.pair0.b   <= b0;
        req.pair1.a   <= a1;
        req.pair1.b   <= b1;
        req.clear     <= clear;
        products = a0 * b0 + a1 * b1; // 24-bit context
        if (clear) begin
            model_acc = products;
        end else begin
            model_acc = model_acc + products; // wraps mod 2^24
        end
        model_sums[sent_count]  = model_acc;
        model_tests[sent_count] = test_name;
        sent_count++;
    endtask

    task automatic idle_for(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (checked_count != sent_count && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (checked_count != sent_count) begin
            missing_errors++;
            $display("%s: %0d results never arrived", test_name, sent_count - checked_count);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] ctl;
        int          gap;
        int          total_errors;
        in_valid   = 1'b0;
        req        = '0;
        model_acc  = '0;
        sent_count = 0;
        seed       = 32'hed70;
        test_name  = "reset";
        wait (rst_n === 1'b1);
        idle_for(IDLE_CYCLES); // outputs must stay quiet here

        test_name = "corners";
        send_request(8'd0, 8'd0, 8'd0, 8'd0, 1'b1);
        idle_for(CORNER_GAP);
        send_request(8'd1, 8'd1, 8'd1, 8'd1, 1'b1);
        idle_for(CORNER_GAP);
        send_request(8'd255, 8'd255, 8'd255, 8'd255, 1'b1);
        idle_for(CORNER_GAP);
        send_request(8'd255, 8'd255, 8'd0, 8'd7, 1'b1);
        idle_for(CORNER_GAP);
        send_request(8'd1, 8'd255, 8'd255, 8'd1, 1'b1);
        idle_for(CORNER_GAP);
        send_request(8'd0, 8'd255, 8'd255, 8'd0, 1'b1);
        drain_results();

        test_name = "back_to_back";
        for (int i = 0; i < N_RUN; i++) begin
            send_request(8'(i * 21 + 5), 8'(255 - i * 9), 8'(i * 13), 8'(i + 200), i == 0);
        end
        drain_results();

        test_name = "mid_clear"; // continues the previous sum until i == 5
        for (int i = 0; i < N_MID; i++) begin
            send_request(8'(i * 37 + 11), 8'(i * 5 + 90), 8'(250 - i * 3), 8'(i * 29), i == 5);
        end
        drain_results();

        test_name = "wrap";
        for (int i = 0; i < N_WRAP; i++) begin
            send_request(8'd255, 8'd255, 8'd255, 8'd255, i == 0);
        end
        drain_results();

        test_name = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            ctl = $random(seed);
            send_request(rnd[7:0], rnd[15:8], rnd[23:16], rnd[31:24], ctl[2:0] == 3'd0);
            gap = ctl[9:8] % (MAX_GAP + 1);
            if (gap > 0) begin
                idle_for(gap);
            end
        end
        drain_results();

        total_errors = value_errors + latency_errors + reset_errors + missing_errors;
        $display("errors: value %0d, latency %0d, reset %0d, missing %0d",
                 value_errors, latency_errors, reset_errors, missing_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge
    end

endmodule
